// File: compile.f
src/snes_cart_pkg.sv
src/rom_header_detect.sv
src/cheat_code_assembler.sv
src/backup_sequencer.sv
src/snes_cart_ctrl.sv
tests/tb_snes_cart_ctrl.sv

// File: src/backup_sequencer.sv
/* Backup RAM sector sequencer */
`timescale 1ns/1ns
`default_nettype none

module backup_sequencer
	import snes_cart_pkg::*;
(
	input  wire         clk_sys,
	input  wire         RESET,
	input  wire         cart_loading_i,
	input  wire  [23:0] ram_mask_i,
	input  wire         img_mounted_i,
	input  wire         img_readonly_i,
	input  wire  [31:0] img_size_i,
	input  wire         bk_load_i,
	input  wire         bk_save_i,
	input  wire         autosave_i,
	input  wire         osd_open_i,
	input  wire         bsram_wr_i,
	input  wire         credit_return_i,
	output sector_req_t sector_req_o,
	output logic        sector_valid_o,
	output logic        bk_busy_o,
	output logic        bk_loading_o,
	output logic        bk_pending_o,
	output logic        bk_enabled_o
);

	logic        cart_load_d;
	logic        load_q;
	logic        save_q;
	logic        save_req;
	logic        load_rise;
	logic        save_rise;
	logic        auto_load;
	logic        start;
	logic        bk_ena;
	logic        pending;
	logic        busy;
	logic        loading;
	logic        all_issued;
	logic        issue;
	logic [1:0]  credits;
	logic [31:0] next_lba;
	logic [31:0] lba_q;
	logic        valid_q;

	assign save_req  = bk_save_i | (pending & osd_open_i & autosave_i);
	assign load_rise = bk_load_i & ~load_q;
	assign save_rise = save_req & ~save_q;
	assign auto_load = cart_load_d & ~cart_loading_i & (|img_size_i);
	assign start     = bk_ena & ~busy & (load_rise | save_rise | auto_load);
	assign issue     = busy & ~all_issued & (credits != 2'd0);

	// ==================================================================
	// Enable and dirty tracking
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_load_d <= 1'b0;
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			bk_ena      <= 1'b0;
			pending     <= 1'b0;
		end else begin
			cart_load_d <= cart_loading_i;
			load_q      <= bk_load_i;
			save_q      <= save_req;

			if (~cart_load_d & cart_loading_i)
				bk_ena <= 1'b0;
			// Save image is mounted by the end of the download
			if (cart_loading_i && img_mounted_i && !img_readonly_i)
				bk_ena <= |ram_mask_i;

			if (start)
				pending <= 1'b0;
			else if (bk_ena && !osd_open_i && bsram_wr_i)
				pending <= 1'b1;
		end
	end

	// ==================================================================
	// Transfer control
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy       <= 1'b0;
			loading    <= 1'b0;
			all_issued <= 1'b0;
			credits    <= SECTOR_CREDITS;
			next_lba   <= 32'd0;
			valid_q    <= 1'b0;
		end else begin
			valid_q <= issue;
			credits <= credits - {1'b0, issue} + {1'b0, credit_return_i};

			if (start) begin
				busy       <= 1'b1;
				loading    <= load_rise | auto_load;
				all_issued <= 1'b0;
				next_lba   <= 32'd0;
			end

			if (issue) begin
				next_lba <= next_lba + 32'd1;
				if (next_lba >= {17'd0, ram_mask_i[23:9]})
					all_issued <= 1'b1;
			end

			// Done once every credit is home again
			if (busy && all_issued && credit_return_i &&
				credits == SECTOR_CREDITS - 2'd1) begin
				busy    <= 1'b0;
				loading <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue)
			lba_q <= next_lba;
	end

	assign sector_req_o.lba   = lba_q;
	assign sector_req_o.write = ~loading;
	assign sector_valid_o     = valid_q;
	assign bk_busy_o          = busy;
	assign bk_loading_o       = loading;
	assign bk_pending_o       = pending;
	assign bk_enabled_o       = bk_ena;

endmodule

`default_nettype wire

// File: src/cheat_code_assembler.sv
/* Cheat code assembler */
`timescale 1ns/1ns
`default_nettype none

module cheat_code_assembler
	import snes_cart_pkg::*;
(
	input  wire         clk_sys,
	input  wire         RESET,
	input  load_word_t  load_i,
	output cheat_code_t cheat_o,
	output logic        cheat_valid_o,
	output logic        cheat_reset_o
);

	logic        cheat_wr;
	logic        cart_load;
	cheat_code_t code_q;
	logic        valid_q;
	logic        reset_q;

	assign cheat_wr  = load_i.download & (load_i.index == CHEAT_INDEX) & load_i.wr;
	assign cart_load = load_i.download & (load_i.index != CHEAT_INDEX);

	// Half-word placement, big-endian words from the loader
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (load_i.addr[3:0])
				4'd0:  code_q.flags[15:0]    <= load_i.data;
				4'd2:  code_q.flags[31:16]   <= load_i.data;
				4'd4:  code_q.address[15:0]  <= load_i.data;
				4'd6:  code_q.address[31:16] <= load_i.data;
				4'd8:  code_q.compare[15:0]  <= load_i.data;
				4'd10: code_q.compare[31:16] <= load_i.data;
				4'd12: code_q.replace[15:0]  <= load_i.data;
				4'd14: code_q.replace[31:16] <= load_i.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			valid_q <= 1'b0;
			reset_q <= 1'b0;
		end else begin
			valid_q <= cheat_wr && (load_i.addr[3:0] == 4'd14);    // Last word of a code
			reset_q <= (cheat_wr && load_i.addr == 25'd0) || cart_load;
		end
	end

	assign cheat_o       = code_q;
	assign cheat_valid_o = valid_q;
	assign cheat_reset_o = reset_q;

endmodule

`default_nettype wire

// File: src/rom_header_detect.sv
/* ROM header decoder */
`timescale 1ns/1ns
`default_nettype none

module rom_header_detect
	import snes_cart_pkg::*;
(
	input  wire          clk_sys,
	input  wire          RESET,
	input  load_word_t   load_i,
	input  header_mode_e header_mode_i,
	input  wire [1:0]    video_region_i,
	output cart_info_t   cart_info_o,
	output logic         cart_loading_o,
	output logic         pal_o
);

	logic        cart_load;
	logic        cart_wr;
	logic        forced_map;
	logic [24:0] size_addr;      // ROM size byte for the forced map
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [7:0]  rom_type;
	logic        rom_region;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic        pal_q;

	assign cart_load = load_i.download & (load_i.index != CHEAT_INDEX);
	assign cart_wr   = cart_load & load_i.wr;

	always_comb begin
		forced_map = 1'b1;
		case (header_mode_i)
			hdr_lorom:   size_addr = LOROM_HDR + HEADER_SKIP;
			hdr_hirom:   size_addr = HIROM_HDR + HEADER_SKIP;
			hdr_exhirom: size_addr = EXHIROM_HDR + HEADER_SKIP;
			default: begin
				forced_map = 1'b0;
				size_addr  = EXHIROM_HDR + HEADER_SKIP;  // Unused in auto/no header
			end
		endcase
	end

	// ==================================================================
	// Header fields
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (cart_wr) begin
			if (load_i.addr == 25'd0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Loader places packed size codes in the first byte
				if (header_mode_i == hdr_auto && load_i.data[7:0] != 8'd0)
					{ram_size, rom_size} <= load_i.data[7:0];

				case (header_mode_i)
					hdr_no_header: rom_type <= 8'd0;
					hdr_lorom:     rom_type <= 8'd0;
					hdr_hirom:     rom_type <= 8'd1;
					hdr_exhirom:   rom_type <= 8'd2;
					default:       rom_type <= load_i.data[15:8];
				endcase
			end

			if (load_i.addr == 25'd2)
				rom_region <= load_i.data[8];

			if (forced_map) begin
				if (load_i.addr == size_addr)
					rom_size <= load_i.data[11:8];
				if (load_i.addr == size_addr + 25'd2)   // RAM size byte
					ram_size <= load_i.data[3:0];
			end
		end
	end

	// Masks follow the size codes one cycle later
	always_ff @(posedge clk_sys) begin
		rom_mask <= (SIZE_UNIT << rom_size) - 24'd1;
		ram_mask <= (ram_size != 4'd0) ? (SIZE_UNIT << ram_size) - 24'd1 : 24'd0;
	end

	// ==================================================================
	// Video region
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET)
			pal_q <= 1'b0;
		else if (!cart_load)
			pal_q <= (video_region_i == 2'd0) ? rom_region : video_region_i[1];
	end

	assign cart_info_o.rom_type = rom_type;
	assign cart_info_o.rom_mask = rom_mask;
	assign cart_info_o.ram_mask = ram_mask;
	assign cart_loading_o       = cart_load;
	assign pal_o                = pal_q;

endmodule

`default_nettype wire

// File: src/snes_cart_ctrl.sv
/* Cartridge control top level */
`timescale 1ns/1ns
`default_nettype none

module snes_cart_ctrl
	import snes_cart_pkg::*;
(
	input  wire          clk_sys,
	input  wire          RESET,
	input  load_word_t   load_i,
	input  header_mode_e header_mode_i,
	input  wire  [1:0]   video_region_i,
	input  wire          img_mounted_i,
	input  wire          img_readonly_i,
	input  wire  [31:0]  img_size_i,
	input  wire          bk_load_i,
	input  wire          bk_save_i,
	input  wire          autosave_i,
	input  wire          osd_open_i,
	input  wire          bsram_wr_i,
	input  wire          credit_return_i,
	output cart_info_t   cart_info_o,
	output logic         cart_loading_o,
	output logic         pal_o,
	output cheat_code_t  cheat_o,
	output logic         cheat_valid_o,
	output logic         cheat_reset_o,
	output sector_req_t  sector_req_o,
	output logic         sector_valid_o,
	output logic         bk_busy_o,
	output logic         bk_loading_o,
	output logic         bk_pending_o,
	output logic         bk_enabled_o
);

	// Header decode and cheat capture share the load stream
	rom_header_detect u_header (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.load_i         (load_i),
		.header_mode_i  (header_mode_i),
		.video_region_i (video_region_i),
		.cart_info_o    (cart_info_o),
		.cart_loading_o (cart_loading_o),
		.pal_o          (pal_o)
	);

	cheat_code_assembler u_cheat (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.load_i        (load_i),
		.cheat_o       (cheat_o),
		.cheat_valid_o (cheat_valid_o),
		.cheat_reset_o (cheat_reset_o)
	);

	backup_sequencer u_backup (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.cart_loading_i  (cart_loading_o),
		.ram_mask_i      (cart_info_o.ram_mask),
		.img_mounted_i   (img_mounted_i),
		.img_readonly_i  (img_readonly_i),
		.img_size_i      (img_size_i),
		.bk_load_i       (bk_load_i),
		.bk_save_i       (bk_save_i),
		.autosave_i      (autosave_i),
		.osd_open_i      (osd_open_i),
		.bsram_wr_i      (bsram_wr_i),
		.credit_return_i (credit_return_i),
		.sector_req_o    (sector_req_o),
		.sector_valid_o  (sector_valid_o),
		.bk_busy_o       (bk_busy_o),
		.bk_loading_o    (bk_loading_o),
		.bk_pending_o    (bk_pending_o),
		.bk_enabled_o    (bk_enabled_o)
	);

endmodule

`default_nettype wire

// File: src/snes_cart_pkg.sv
/* Cartridge control shared types */
`default_nettype none

package snes_cart_pkg;

	// ==================================================================
	// Constants
	// ==================================================================

	localparam logic [7:0]  CHEAT_INDEX      = 8'hFF;     // Loader index for cheat files
	localparam logic [24:0] HEADER_SKIP      = 25'h200;   // Copier header in front of ROM
	localparam logic [24:0] LOROM_HDR        = 25'h7FD6;
	localparam logic [24:0] HIROM_HDR        = 25'hFFD6;
	localparam logic [24:0] EXHIROM_HDR      = 25'h40FFD6;
	localparam logic [3:0]  DEFAULT_ROM_SIZE = 4'hC;
	localparam logic [23:0] SIZE_UNIT        = 24'd1024;  // 1 KiB base for both masks
	localparam logic [1:0]  SECTOR_CREDITS   = 2'd2;      // SD host buffer depth

	// ==================================================================
	// Types
	// ==================================================================

	// ROM header menu setting
	typedef enum logic [2:0] {
		hdr_auto      = 3'd0,
		hdr_no_header = 3'd1,
		hdr_lorom     = 3'd2,
		hdr_hirom     = 3'd3,
		hdr_exhirom   = 3'd4
	} header_mode_e;

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} load_word_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
	} cart_info_t;

	// Field order matches the cheat engine bus
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        write;     // 1 = save to card
	} sector_req_t;

endpackage

`default_nettype wire

// File: tests/tb_snes_cart_ctrl.sv
/* Cartridge control testbench */
`timescale 1ns/1ns
`default_nettype none

module tb_snes_cart_ctrl
	import snes_cart_pkg::*;
();

	localparam int CLK_PERIOD      = 100;
	localparam int WATCHDOG_CYCLES = 20000;   // Longest transfer is 32 sectors of up to 7 cycles

	logic         clk_sys;
	logic         RESET;
	load_word_t   load;
	header_mode_e header_mode;
	logic [1:0]   video_region;
	logic         img_mounted;
	logic         img_readonly;
	logic [31:0]  img_size;
	logic         bk_load;
	logic         bk_save;
	logic         autosave;
	logic         osd_open;
	logic         bsram_wr;
	logic         credit_return_i;
	cart_info_t   cart_info;
	logic         cart_loading;
	logic         pal;
	cheat_code_t  cheat;
	logic         cheat_valid;
	logic         cheat_reset;
	sector_req_t  sector_req;
	logic         sector_valid;
	logic         bk_busy;
	logic         bk_loading;
	logic         bk_pending;
	logic         bk_enabled;

	int   cycle_no;
	int   issued;
	int   returned;
	int   expect_lba;
	int   cheat_pulses;
	int   due_q[$];        // Cycle numbers of pending credit returns
	logic cheat_prev;
	logic load_prev;
	logic xfer_armed;
	logic xfer_write;

	snes_cart_ctrl u_dut (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.load_i          (load),
		.header_mode_i   (header_mode),
		.video_region_i  (video_region),
		.img_mounted_i   (img_mounted),
		.img_readonly_i  (img_readonly),
		.img_size_i      (img_size),
		.bk_load_i       (bk_load),
		.bk_save_i       (bk_save),
		.autosave_i      (autosave),
		.osd_open_i      (osd_open),
		.bsram_wr_i      (bsram_wr),
		.credit_return_i (credit_return_i),
		.cart_info_o     (cart_info),
		.cart_loading_o  (cart_loading),
		.pal_o           (pal),
		.cheat_o         (cheat),
		.cheat_valid_o   (cheat_valid),
		.cheat_reset_o   (cheat_reset),
		.sector_req_o    (sector_req),
		.sector_valid_o  (sector_valid),
		.bk_busy_o       (bk_busy),
		.bk_loading_o    (bk_loading),
		.bk_pending_o    (bk_pending),
		.bk_enabled_o    (bk_enabled)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Watchdog expired before the test sequence finished");
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else
			abort_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic set_download(input logic active, input logic [7:0] index);
		step();
		load.download = active;
		load.index    = index;
	endtask

	task automatic load_write(input logic [24:0] addr, input logic [15:0] data);
		step();
		load.addr = addr;
		load.data = data;
		load.wr   = 1'b1;
		step();
		load.wr   = 1'b0;
	endtask

	// Ones in the low 10 + code bits, capped at the 24-bit field
	function automatic logic [23:0] size_mask(input logic [3:0] code);
		logic [23:0] mask;
		mask = '0;
		for (int i = 0; i < 24; i++)
			mask[i] = (i < 10 + code);
		return mask;
	endfunction

	function automatic logic [23:0] ram_mask_of(input logic [3:0] code);
		return (code == 4'd0) ? 24'd0 : size_mask(code);
	endfunction

	task automatic check_idle();
		@(negedge clk_sys);
		check_value("sector_valid_o", sector_valid, 1'b0);
		check_value("bk_busy_o", bk_busy, 1'b0);
		check_value("bk_loading_o", bk_loading, 1'b0);
		check_value("bk_pending_o", bk_pending, 1'b0);
		check_value("bk_enabled_o", bk_enabled, 1'b0);
		check_value("cheat_valid_o", cheat_valid, 1'b0);
		check_value("cart_loading_o", cart_loading, 1'b0);
	endtask

	task automatic arm_transfer(input logic write);
		xfer_write = write;
		issued     = 0;
		returned   = 0;
		expect_lba = 0;
		xfer_armed = 1'b1;
	endtask

	task automatic wait_busy(input logic level);
		do @(negedge clk_sys); while (bk_busy !== level);
	endtask

	task automatic close_transfer(input int sectors);
		wait_busy(1'b0);
		check_value("sector request count", issued, sectors);
		check_value("sectors outstanding at bk_busy_o fall", issued - returned, 0);
		xfer_armed = 1'b0;
	endtask

	// ======================================================================
	// Sector host model and request checks
	// ======================================================================

	initial begin
		int due;

		forever begin
			@(negedge clk_sys);
			if (sector_valid === 1'b1) begin
				assert (xfer_armed) else
					abort_run("Sector request seen outside a backup transfer");
				check_value("sector_req_o.lba", sector_req.lba, expect_lba);
				check_value("sector_req_o.write", sector_req.write, xfer_write);
				issued++;
				expect_lba++;
				assert (issued - returned <= SECTOR_CREDITS) else
					abort_run("More sectors outstanding than the host granted credits");
				due = cycle_no + $urandom_range(1, 6);
				if (due_q.size() > 0 && due <= due_q[$])
					due = due_q[$] + 1;    // One credit per cycle, in order
				due_q.push_back(due);
			end
			step();
			cycle_no++;
			credit_return_i = 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle_no) begin
				void'(due_q.pop_front());
				credit_return_i = 1'b1;
				returned++;
			end
		end
	end

	// Strobe width, cart load flag and cheat reset during cart loads
	always @(negedge clk_sys) begin
		logic cart_load_exp;

		cart_load_exp = load.download && (load.index != CHEAT_INDEX);
		if (cheat_valid === 1'b1) begin
			assert (cheat_prev !== 1'b1) else
				abort_run("cheat_valid_o stayed high for more than one cycle");
			cheat_pulses++;
		end
		check_value("cart_loading_o", cart_loading, cart_load_exp);
		if (load_prev === 1'b1)
			check_value("cheat_reset_o", cheat_reset, 1'b1);
		cheat_prev = cheat_valid;
		load_prev  = cart_load_exp;
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [7:0]  sizes;
		logic [7:0]  map_byte;
		logic [15:0] word2;
		logic [3:0]  rom_code;
		logic [3:0]  ram_code;
		logic [15:0] words [8];
		logic [23:0] ram_mask_exp;

		void'($urandom(32'hba0c_091f));
		RESET           = 1'b1;
		load            = '0;
		header_mode     = hdr_auto;
		video_region    = 2'd0;
		img_mounted     = 1'b0;
		img_readonly    = 1'b0;
		img_size        = 32'd0;
		bk_load         = 1'b0;
		bk_save         = 1'b0;
		autosave        = 1'b0;
		osd_open        = 1'b0;
		bsram_wr        = 1'b0;
		credit_return_i = 1'b0;
		cycle_no        = 0;
		cheat_pulses    = 0;
		cheat_prev      = 1'b0;
		load_prev       = 1'b0;
		arm_transfer(1'b0);
		xfer_armed      = 1'b0;

		repeat (8) step();
		RESET = 1'b0;
		repeat (3) check_idle();

		// Auto header: packed size codes and map byte at address 0
		sizes    = $urandom_range(1, 255);
		map_byte = $urandom;
		word2    = $urandom;
		word2[8] = 1'b1;        // PAL header, differs from the reset value
		set_download(1'b1, 8'h00);
		load_write(25'd0, {map_byte, sizes});
		load_write(25'd2, word2);
		set_download(1'b0, 8'h00);
		repeat (3) step();
		@(negedge clk_sys);
		check_value("cart_info_o.rom_type", cart_info.rom_type, map_byte);
		check_value("cart_info_o.rom_mask", cart_info.rom_mask, size_mask(sizes[3:0]));
		check_value("cart_info_o.ram_mask", cart_info.ram_mask, ram_mask_of(sizes[7:4]));
		check_value("pal_o", pal, word2[8]);

		// Forced HiROM behind a copier header, PAL forced on
		step();
		header_mode  = hdr_hirom;
		video_region = 2'd2;
		rom_code     = $urandom_range(0, 11);   // Never the default size
		ram_code     = $urandom_range(1, 15);
		set_download(1'b1, 8'h00);
		load_write(25'd0, 16'($urandom));
		word2    = $urandom;
		word2[8] = 1'b0;        // NTSC header, the menu overrides it
		load_write(25'd2, word2);
		word2       = $urandom;
		word2[11:8] = rom_code;
		load_write(HIROM_HDR + HEADER_SKIP, word2);
		word2      = $urandom;
		word2[3:0] = ram_code;
		load_write(HIROM_HDR + HEADER_SKIP + 25'd2, word2);
		set_download(1'b0, 8'h00);
		repeat (3) step();
		@(negedge clk_sys);
		check_value("cart_info_o.rom_type", cart_info.rom_type, 8'd1);
		check_value("cart_info_o.rom_mask", cart_info.rom_mask, size_mask(rom_code));
		check_value("cart_info_o.ram_mask", cart_info.ram_mask, ram_mask_of(ram_code));
		check_value("pal_o", pal, 1'b1);

		// Cheat download of one code
		cheat_pulses = 0;
		set_download(1'b1, CHEAT_INDEX);
		for (int i = 0; i < 8; i++) begin
			words[i] = $urandom;
			load_write(25'(2 * i), words[i]);
			if (i == 0) begin
				@(negedge clk_sys);
				check_value("cheat_reset_o", cheat_reset, 1'b1);
			end
		end
		set_download(1'b0, 8'h00);
		repeat (2) step();
		@(negedge clk_sys);
		check_value("cheat_valid_o pulse count", cheat_pulses, 1);
		check_value("cheat_o.flags", cheat.flags, {words[1], words[0]});
		check_value("cheat_o.address", cheat.address, {words[3], words[2]});
		check_value("cheat_o.compare", cheat.compare, {words[5], words[4]});
		check_value("cheat_o.replace", cheat.replace, {words[7], words[6]});

		// Cart load with a writable save image ends in an automatic load
		step();
		header_mode  = hdr_auto;
		video_region = 2'd0;
		img_mounted  = 1'b1;
		img_size     = 32'h0000_8000;
		ram_code     = $urandom_range(1, 4);
		rom_code     = $urandom;
		ram_mask_exp = size_mask(ram_code);
		arm_transfer(1'b0);
		set_download(1'b1, 8'h00);
		load_write(25'd0, {8'($urandom), ram_code, rom_code});
		load_write(25'd2, 16'($urandom));
		step();
		set_download(1'b0, 8'h00);
		wait_busy(1'b1);
		check_value("cart_info_o.ram_mask", cart_info.ram_mask, ram_mask_exp);
		check_value("bk_enabled_o", bk_enabled, 1'b1);
		check_value("bk_loading_o", bk_loading, 1'b1);
		close_transfer(ram_mask_exp[23:9] + 1);

		// Dirty backup RAM saved when the menu opens with autosave on
		step();
		bsram_wr = 1'b1;
		step();
		bsram_wr = 1'b0;
		@(negedge clk_sys);
		check_value("bk_pending_o", bk_pending, 1'b1);
		arm_transfer(1'b1);
		step();
		autosave = 1'b1;
		osd_open = 1'b1;
		wait_busy(1'b1);
		check_value("bk_pending_o", bk_pending, 1'b0);
		close_transfer(ram_mask_exp[23:9] + 1);
		step();
		osd_open = 1'b0;
		autosave = 1'b0;
		repeat (2) step();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
